//--- filelist.f
source/mmacc_feed_pkg.sv
source/mmacc_feed_read.sv
source/mmacc_feed_rot.sv
source/mmacc_feed_join.sv
source/mmacc_feed_core.sv
verification/tb_clk_gen.sv
verification/tb_gram_model.sv
verification/tb_mmacc_feed.sv

//--- run_sim.sh
#!/bin/sh
# Build the feed stage testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module tb_mmacc_feed -o sim_tb > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0

//--- source/mmacc_feed_core.sv
// Feed stage top
// Read controller, two rotation halves each owning a pair of GRAM
// banks, and the join that produces the data and CMUX difference

`timescale 1ns/1ps

module mmacc_feed_core (
  input  logic                                   clk,
  input  logic                                   arst_n_i,

  input  logic [mmacc_feed_pkg::MCMD_W-1:0]      in_mcmd_i,
  input  logic                                   in_mcmd_vld_i,
  output logic                                   in_mcmd_rdy_o,

  // GRAM read ports, per bank and per port
  output logic [mmacc_feed_pkg::BANK_NB-1:0][1:0]                                gram_rd_en_o,
  output logic [mmacc_feed_pkg::BANK_NB-1:0][1:0][mmacc_feed_pkg::GRAM_ADD_W-1:0] gram_rd_add_o,
  input  logic [mmacc_feed_pkg::BANK_NB-1:0][1:0][mmacc_feed_pkg::MOD_Q_W-1:0]    gram_rd_data_i,
  input  logic [mmacc_feed_pkg::BANK_NB-1:0][1:0]                                gram_rd_avail_i,

  output logic [mmacc_feed_pkg::BANK_NB-1:0][mmacc_feed_pkg::MOD_Q_W-1:0]        out_data_o,
  output logic [mmacc_feed_pkg::BANK_NB-1:0][mmacc_feed_pkg::MOD_Q_W-1:0]        out_diff_o,
  output logic [mmacc_feed_pkg::CHUNK_W-1:0]                                     out_chunk_o,
  output logic                                                                   out_avail_o
);

  // ============================================================
  // Read controller
  // ============================================================
  logic                                   step_vld;
  logic [mmacc_feed_pkg::SLOT_W-1:0]      step_slot;
  logic [mmacc_feed_pkg::CHUNK_W-1:0]     step_chunk;
  logic [mmacc_feed_pkg::ROT_W-1:0]       step_rot;

  mmacc_feed_read mmacc_feed_read_i (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .in_mcmd_i     (in_mcmd_i),
    .in_mcmd_vld_i (in_mcmd_vld_i),
    .in_mcmd_rdy_o (in_mcmd_rdy_o),
    .step_vld_o    (step_vld),
    .step_slot_o   (step_slot),
    .step_chunk_o  (step_chunk),
    .step_rot_o    (step_rot)
  );

  // ============================================================
  // Rotation halves
  // ============================================================
  logic [mmacc_feed_pkg::HALF_NB-1:0]                                                    half_vld;
  logic [mmacc_feed_pkg::HALF_NB-1:0][mmacc_feed_pkg::HALF_BANK_NB-1:0][mmacc_feed_pkg::MOD_Q_W-1:0]
                                                                                         half_data;
  logic [mmacc_feed_pkg::HALF_NB-1:0][mmacc_feed_pkg::HALF_BANK_NB-1:0][mmacc_feed_pkg::MOD_Q_W-1:0]
                                                                                         half_rot;
  logic [mmacc_feed_pkg::HALF_NB-1:0][mmacc_feed_pkg::ROT_W-1:0]                         half_rot_k;
  logic [mmacc_feed_pkg::HALF_NB-1:0][mmacc_feed_pkg::CHUNK_W-1:0]                       half_chunk;

  for (genvar h = 0; h < mmacc_feed_pkg::HALF_NB; h++) begin : gen_half
    mmacc_feed_rot #(
      .HALF_ID (h)
    ) mmacc_feed_rot_i (
      .clk             (clk),
      .arst_n_i        (arst_n_i),
      .step_vld_i      (step_vld),
      .step_slot_i     (step_slot),
      .step_chunk_i    (step_chunk),
      .step_rot_i      (step_rot),
      .gram_rd_en_o    (gram_rd_en_o[h*mmacc_feed_pkg::HALF_BANK_NB +: mmacc_feed_pkg::HALF_BANK_NB]),
      .gram_rd_add_o   (gram_rd_add_o[h*mmacc_feed_pkg::HALF_BANK_NB +: mmacc_feed_pkg::HALF_BANK_NB]),
      .gram_rd_data_i  (gram_rd_data_i[h*mmacc_feed_pkg::HALF_BANK_NB +: mmacc_feed_pkg::HALF_BANK_NB]),
      .gram_rd_avail_i (gram_rd_avail_i[h*mmacc_feed_pkg::HALF_BANK_NB +: mmacc_feed_pkg::HALF_BANK_NB]),
      .half_vld_o      (half_vld[h]),
      .half_data_o     (half_data[h]),
      .half_rot_o      (half_rot[h]),
      .half_rot_k_o    (half_rot_k[h]),
      .half_chunk_o    (half_chunk[h])
    );
  end

  // ============================================================
  // Join
  // ============================================================
  // Control side info taken from the upper half
  mmacc_feed_join mmacc_feed_join_i (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .half_vld_i   (half_vld),
    .half_data_i  (half_data),
    .half_rot_i   (half_rot),
    .half_rot_k_i (half_rot_k[mmacc_feed_pkg::HALF_NB-1]),
    .half_chunk_i (half_chunk[mmacc_feed_pkg::HALF_NB-1]),
    .out_data_o   (out_data_o),
    .out_diff_o   (out_diff_o),
    .out_chunk_o  (out_chunk_o),
    .out_avail_o  (out_avail_o)
  );

endmodule

//--- source/mmacc_feed_join.sv
// Feed join
// Gathers the rotated lanes of both halves into their final lane
// position (b + k) mod 4, then forms the CMUX difference
// rotated - original mod q. Outputs are registered.

`timescale 1ns/1ps

module mmacc_feed_join (
  input  logic                                   clk,
  input  logic                                   arst_n_i,

  input  logic [mmacc_feed_pkg::HALF_NB-1:0]     half_vld_i,
  input  logic [mmacc_feed_pkg::HALF_NB-1:0][mmacc_feed_pkg::HALF_BANK_NB-1:0][mmacc_feed_pkg::MOD_Q_W-1:0]
                                                 half_data_i,
  input  logic [mmacc_feed_pkg::HALF_NB-1:0][mmacc_feed_pkg::HALF_BANK_NB-1:0][mmacc_feed_pkg::MOD_Q_W-1:0]
                                                 half_rot_i,
  input  logic [mmacc_feed_pkg::ROT_W-1:0]       half_rot_k_i,
  input  logic [mmacc_feed_pkg::CHUNK_W-1:0]     half_chunk_i,

  output logic [mmacc_feed_pkg::BANK_NB-1:0][mmacc_feed_pkg::MOD_Q_W-1:0] out_data_o,
  output logic [mmacc_feed_pkg::BANK_NB-1:0][mmacc_feed_pkg::MOD_Q_W-1:0] out_diff_o,
  output logic [mmacc_feed_pkg::CHUNK_W-1:0]                              out_chunk_o,
  output logic                                                            out_avail_o
);

  // ============================================================
  // Lane rotation across halves
  // ============================================================
  // Flattened views, bank b = half * HALF_BANK_NB + index
  logic [mmacc_feed_pkg::BANK_NB-1:0][mmacc_feed_pkg::MOD_Q_W-1:0] data_lane;
  logic [mmacc_feed_pkg::BANK_NB-1:0][mmacc_feed_pkg::MOD_Q_W-1:0] rot_bank;
  logic [mmacc_feed_pkg::BANK_NB-1:0][mmacc_feed_pkg::MOD_Q_W-1:0] rot_lane;
  logic [mmacc_feed_pkg::BANK_NB-1:0][mmacc_feed_pkg::MOD_Q_W-1:0] diff_lane;

  assign data_lane = half_data_i;
  assign rot_bank  = half_rot_i;

  always_comb begin
    logic [mmacc_feed_pkg::LANE_W-1:0] src_bank;
    for (int m = 0; m < mmacc_feed_pkg::BANK_NB; m++) begin
      // Lane m is fed by bank (m - k) mod 4
      src_bank    = mmacc_feed_pkg::LANE_W'(m) - half_rot_k_i[mmacc_feed_pkg::LANE_W-1:0];
      rot_lane[m] = rot_bank[src_bank];
    end
  end

  // ============================================================
  // CMUX subtraction mod q
  // ============================================================
  always_comb begin
    logic [mmacc_feed_pkg::MOD_Q_W:0] sub;
    for (int m = 0; m < mmacc_feed_pkg::BANK_NB; m++) begin
      sub = {1'b0, rot_lane[m]} - {1'b0, data_lane[m]};
      // Borrow out means the result went negative
      if (sub[mmacc_feed_pkg::MOD_Q_W])
        diff_lane[m] = sub[mmacc_feed_pkg::MOD_Q_W-1:0] + mmacc_feed_pkg::MOD_Q;
      else
        diff_lane[m] = sub[mmacc_feed_pkg::MOD_Q_W-1:0];
    end
  end

  // ============================================================
  // Output register
  // ============================================================
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) out_avail_o <= 1'b0;
    else           out_avail_o <= half_vld_i[0];
  end

  always_ff @(posedge clk) begin
    if (half_vld_i[0]) begin
      out_data_o  <= data_lane;
      out_diff_o  <= diff_lane;
      out_chunk_o <= half_chunk_i;
    end
  end

  // Both halves run in lockstep
  a_half_sync : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    half_vld_i[0] == half_vld_i[1]
  ) else $error("feed_join: half valids disagree");

endmodule

//--- source/mmacc_feed_pkg.sv
// Feed stage shared sizes
// Polynomial, chunk and GRAM geometry, coefficient width and modulus
// for the blind-rotation multiply-accumulate feed path

package mmacc_feed_pkg;

  // ============================================================
  // Polynomial geometry
  // ============================================================
  localparam int POLY_N       = 16;
  // k spans 0 to 2*POLY_N-1 for the negacyclic rotation
  localparam int ROT_W        = $clog2(2 * POLY_N);

  // ============================================================
  // GRAM organisation
  // ============================================================
  localparam int BANK_NB      = 4;
  localparam int LANE_W       = $clog2(BANK_NB);
  localparam int HALF_NB      = 2;
  localparam int HALF_BANK_NB = BANK_NB / HALF_NB;

  localparam int CHUNK_NB     = POLY_N / BANK_NB;
  localparam int CHUNK_W      = $clog2(CHUNK_NB);

  localparam int SLOT_NB      = 4;
  localparam int SLOT_W       = $clog2(SLOT_NB);

  // Address is slot * CHUNK_NB + chunk row
  localparam int GRAM_ADD_W   = SLOT_W + CHUNK_W;

  // Read enable to data return
  localparam int RAM_LATENCY  = 2;

  // ============================================================
  // Coefficients
  // ============================================================
  localparam int MOD_Q_W      = 16;
  localparam logic [MOD_Q_W-1:0] MOD_Q = MOD_Q_W'(65521);

  // ============================================================
  // Command word
  // ============================================================
  // k sits in the low bits, slot in the top bits
  localparam int MCMD_W       = 7;
  localparam int MCMD_ROT_LSB = 0;
  localparam int MCMD_SLOT_LSB = MCMD_W - SLOT_W;

endpackage

//--- source/mmacc_feed_read.sv
// Feed read controller
// Accepts one feed command at a time and walks through the chunks
// of the addressed polynomial, one read step per cycle. Ready goes
// high again on the last step so commands can stream back to back.

`timescale 1ns/1ps

module mmacc_feed_read (
  input  logic                                   clk,
  input  logic                                   arst_n_i,

  input  logic [mmacc_feed_pkg::MCMD_W-1:0]      in_mcmd_i,
  input  logic                                   in_mcmd_vld_i,
  output logic                                   in_mcmd_rdy_o,

  output logic                                   step_vld_o,
  output logic [mmacc_feed_pkg::SLOT_W-1:0]      step_slot_o,
  output logic [mmacc_feed_pkg::CHUNK_W-1:0]     step_chunk_o,
  output logic [mmacc_feed_pkg::ROT_W-1:0]       step_rot_o
);

  // ============================================================
  // Signals
  // ============================================================
  logic                                   busy_q;
  logic [mmacc_feed_pkg::CHUNK_W-1:0]     chunk_q;
  logic [mmacc_feed_pkg::SLOT_W-1:0]      slot_q;
  logic [mmacc_feed_pkg::ROT_W-1:0]       rot_q;

  logic                                   last_step;
  logic                                   accept;
  logic [mmacc_feed_pkg::SLOT_W-1:0]      cmd_slot;
  logic [mmacc_feed_pkg::ROT_W-1:0]       cmd_rot;

  // ============================================================
  // Command decode and handshake
  // ============================================================
  assign cmd_rot  = in_mcmd_i[mmacc_feed_pkg::MCMD_ROT_LSB +: mmacc_feed_pkg::ROT_W];
  assign cmd_slot = in_mcmd_i[mmacc_feed_pkg::MCMD_SLOT_LSB +: mmacc_feed_pkg::SLOT_W];

  // Last chunk of the current polynomial is issued this cycle
  assign last_step = busy_q
                   && (chunk_q == mmacc_feed_pkg::CHUNK_W'(mmacc_feed_pkg::CHUNK_NB - 1));

  assign in_mcmd_rdy_o = ~busy_q | last_step;
  assign accept        = in_mcmd_vld_i & in_mcmd_rdy_o;

  // ============================================================
  // Chunk sequencer
  // ============================================================
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q  <= 1'b0;
      chunk_q <= '0;
    end else begin
      if (accept) begin
        busy_q  <= 1'b1;
        chunk_q <= '0;
      end else if (last_step) begin
        busy_q  <= 1'b0;
        chunk_q <= '0;
      end else if (busy_q) begin
        chunk_q <= chunk_q + 1'b1;
      end
    end
  end

  // Slot and k held for the whole command
  always_ff @(posedge clk) begin
    if (accept) begin
      slot_q <= cmd_slot;
      rot_q  <= cmd_rot;
    end
  end

  assign step_vld_o   = busy_q;
  assign step_slot_o  = slot_q;
  assign step_chunk_o = chunk_q;
  assign step_rot_o   = rot_q;

  // ============================================================
  // Assertions
  // ============================================================
  // First step of a polynomial only right after an acceptance
  a_step_after_accept : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    (step_vld_o && step_chunk_o == '0) |-> $past(accept)
  ) else $error("feed_read: step issued while idle");

  // An accepted command produces one step per chunk without holes
  a_steps_contiguous : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    accept |=> step_vld_o [*mmacc_feed_pkg::CHUNK_NB]
  ) else $error("feed_read: step sequence broken");

endmodule

//--- source/mmacc_feed_rot.sv
// Feed rotation half
// Drives the GRAM reads of one pair of banks: port 0 fetches the
// plain chunk, port 1 fetches the coefficient that lands in the
// rotated lane. Returned port 1 data is negated mod q on wrap.

`timescale 1ns/1ps

module mmacc_feed_rot #(
  parameter int HALF_ID = 0
) (
  input  logic                                   clk,
  input  logic                                   arst_n_i,

  input  logic                                   step_vld_i,
  input  logic [mmacc_feed_pkg::SLOT_W-1:0]      step_slot_i,
  input  logic [mmacc_feed_pkg::CHUNK_W-1:0]     step_chunk_i,
  input  logic [mmacc_feed_pkg::ROT_W-1:0]       step_rot_i,

  output logic [mmacc_feed_pkg::HALF_BANK_NB-1:0][1:0]                                gram_rd_en_o,
  output logic [mmacc_feed_pkg::HALF_BANK_NB-1:0][1:0][mmacc_feed_pkg::GRAM_ADD_W-1:0] gram_rd_add_o,
  input  logic [mmacc_feed_pkg::HALF_BANK_NB-1:0][1:0][mmacc_feed_pkg::MOD_Q_W-1:0]    gram_rd_data_i,
  input  logic [mmacc_feed_pkg::HALF_BANK_NB-1:0][1:0]                                gram_rd_avail_i,

  output logic                                                              half_vld_o,
  output logic [mmacc_feed_pkg::HALF_BANK_NB-1:0][mmacc_feed_pkg::MOD_Q_W-1:0] half_data_o,
  output logic [mmacc_feed_pkg::HALF_BANK_NB-1:0][mmacc_feed_pkg::MOD_Q_W-1:0] half_rot_o,
  output logic [mmacc_feed_pkg::ROT_W-1:0]                                  half_rot_k_o,
  output logic [mmacc_feed_pkg::CHUNK_W-1:0]                                half_chunk_o
);

  // ============================================================
  // Address generation
  // ============================================================
  logic [mmacc_feed_pkg::HALF_BANK_NB-1:0] rot_sign;

  always_comb begin
    logic [mmacc_feed_pkg::LANE_W-1:0] lane;
    logic [mmacc_feed_pkg::ROT_W-1:0]  src;
    for (int i = 0; i < mmacc_feed_pkg::HALF_BANK_NB; i++) begin
      // Output lane served by this bank for the current k
      lane = mmacc_feed_pkg::LANE_W'(HALF_ID * mmacc_feed_pkg::HALF_BANK_NB + i)
           + step_rot_i[mmacc_feed_pkg::LANE_W-1:0];
      // Source index mod 2N, upper half means X^N wrap
      src  = mmacc_feed_pkg::ROT_W'({step_chunk_i, lane}) - step_rot_i;

      gram_rd_en_o[i]     = {2{step_vld_i}};
      gram_rd_add_o[i][0] = {step_slot_i, step_chunk_i};
      gram_rd_add_o[i][1] = {step_slot_i, src[mmacc_feed_pkg::LANE_W +: mmacc_feed_pkg::CHUNK_W]};
      rot_sign[i]         = src[mmacc_feed_pkg::ROT_W-1];
    end
  end

  // ============================================================
  // Read latency alignment
  // ============================================================
  logic [mmacc_feed_pkg::RAM_LATENCY-1:0]                                   dly_vld;
  logic [mmacc_feed_pkg::RAM_LATENCY-1:0][mmacc_feed_pkg::HALF_BANK_NB-1:0] dly_sign;
  logic [mmacc_feed_pkg::RAM_LATENCY-1:0][mmacc_feed_pkg::ROT_W-1:0]        dly_rot;
  logic [mmacc_feed_pkg::RAM_LATENCY-1:0][mmacc_feed_pkg::CHUNK_W-1:0]      dly_chunk;
  logic                                                                     ret_vld;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dly_vld <= '0;
    end else begin
      dly_vld[0] <= step_vld_i;
      for (int s = 1; s < mmacc_feed_pkg::RAM_LATENCY; s++) dly_vld[s] <= dly_vld[s-1];
    end
  end

  // Side info of up to RAM_LATENCY steps in flight
  always_ff @(posedge clk) begin
    dly_sign[0]  <= rot_sign;
    dly_rot[0]   <= step_rot_i;
    dly_chunk[0] <= step_chunk_i;
    for (int s = 1; s < mmacc_feed_pkg::RAM_LATENCY; s++) begin
      dly_sign[s]  <= dly_sign[s-1];
      dly_rot[s]   <= dly_rot[s-1];
      dly_chunk[s] <= dly_chunk[s-1];
    end
  end

  assign ret_vld = dly_vld[mmacc_feed_pkg::RAM_LATENCY-1];

  // ============================================================
  // Sign correction and output register
  // ============================================================
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) half_vld_o <= 1'b0;
    else           half_vld_o <= ret_vld;
  end

  always_ff @(posedge clk) begin
    if (ret_vld) begin
      for (int i = 0; i < mmacc_feed_pkg::HALF_BANK_NB; i++) begin
        half_data_o[i] <= gram_rd_data_i[i][0];
        // -x mod q, zero stays zero
        if (dly_sign[mmacc_feed_pkg::RAM_LATENCY-1][i] && gram_rd_data_i[i][1] != '0)
          half_rot_o[i] <= mmacc_feed_pkg::MOD_Q - gram_rd_data_i[i][1];
        else
          half_rot_o[i] <= gram_rd_data_i[i][1];
      end
      half_rot_k_o <= dly_rot[mmacc_feed_pkg::RAM_LATENCY-1];
      half_chunk_o <= dly_chunk[mmacc_feed_pkg::RAM_LATENCY-1];
    end
  end

  // GRAM must answer exactly RAM_LATENCY cycles after each enable
  a_avail_latency : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    gram_rd_avail_i == {(2 * mmacc_feed_pkg::HALF_BANK_NB){ret_vld}}
  ) else $error("feed_rot %0d: read data avail misaligned", HALF_ID);

endmodule

//--- verification/tb_clk_gen.sv
// Testbench clock source
// Free running clock, starts low

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

endmodule

//--- verification/tb_gram_model.sv
// GRAM model
// Four banks with two read ports each. Data and avail come back a fixed
// RAM_LATENCY cycles after the enable. Word contents follow a fill rule
// built from slot and coefficient index, so every address holds its own value.

`timescale 1ns/1ps

module tb_gram_model #(
  parameter int SLOT_MUL = 131,
  parameter int COEF_MUL = 17,
  parameter int FILL_OFS = 3
) (
  input  logic                                                                      clk,
  input  logic                                                                      arst_n_i,
  input  logic [mmacc_feed_pkg::BANK_NB-1:0][1:0]                                   rd_en_i,
  input  logic [mmacc_feed_pkg::BANK_NB-1:0][1:0][mmacc_feed_pkg::GRAM_ADD_W-1:0]   rd_add_i,
  output logic [mmacc_feed_pkg::BANK_NB-1:0][1:0][mmacc_feed_pkg::MOD_Q_W-1:0]      rd_data_o,
  output logic [mmacc_feed_pkg::BANK_NB-1:0][1:0]                                   rd_avail_o
);

  localparam int LAST = mmacc_feed_pkg::RAM_LATENCY - 1;

  logic [LAST:0][mmacc_feed_pkg::BANK_NB-1:0][1:0]                                 en_pipe;
  logic [LAST:0][mmacc_feed_pkg::BANK_NB-1:0][1:0][mmacc_feed_pkg::GRAM_ADD_W-1:0] add_pipe;

  // Row a of bank b holds coefficient 4*(a mod 4) + b of slot a/4
  function automatic logic [mmacc_feed_pkg::MOD_Q_W-1:0] word_at(input int bank, input int add);
    int slot;
    int coef;
    slot = add / mmacc_feed_pkg::CHUNK_NB;
    coef = (add % mmacc_feed_pkg::CHUNK_NB) * mmacc_feed_pkg::BANK_NB + bank;
    return mmacc_feed_pkg::MOD_Q_W'((slot * SLOT_MUL + coef * COEF_MUL + FILL_OFS)
                                    % int'(mmacc_feed_pkg::MOD_Q));
  endfunction

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_pipe <= '0;
    end else begin
      en_pipe[0] <= rd_en_i;
      for (int s = 1; s <= LAST; s++) en_pipe[s] <= en_pipe[s-1];
    end
  end

  always_ff @(posedge clk) begin
    add_pipe[0] <= rd_add_i;
    for (int s = 1; s <= LAST; s++) add_pipe[s] <= add_pipe[s-1];
  end

  always_comb begin
    for (int b = 0; b < mmacc_feed_pkg::BANK_NB; b++) begin
      for (int p = 0; p < 2; p++) begin
        rd_data_o[b][p] = en_pipe[LAST][b][p] ? word_at(b, int'(add_pipe[LAST][b][p])) : '0;
      end
    end
  end

  assign rd_avail_o = en_pipe[LAST];

endmodule

//--- verification/tb_mmacc_feed.sv
// Feed stage testbench
// Streams random feed commands into the feed core, with and without
// idle gaps, and checks handshake, read timing, port 0 addresses and
// the output chunks against a reference model of the negacyclic rotation

`timescale 1ns/1ps

module tb_mmacc_feed;

  // ============================================================
  // Run setup
  // ============================================================
  localparam int  CMD_NB        = 24;
  localparam int  RST_CYCLES    = 10;
  localparam real CLK_PERIOD_NS = 4.0;
  localparam int  CMD_CYCLES    = 20;
  localparam int  OUT_DELAY     = 5;
  localparam int  SEED          = 32'h45e95467;
  // GRAM fill rule
  localparam int  SLOT_MUL      = 131;
  localparam int  COEF_MUL      = 17;
  localparam int  FILL_OFS      = 3;

  localparam int  Q          = int'(mmacc_feed_pkg::MOD_Q);
  localparam int  N          = mmacc_feed_pkg::POLY_N;
  localparam int  LANES      = mmacc_feed_pkg::BANK_NB;
  localparam int  W          = mmacc_feed_pkg::MOD_Q_W;
  localparam int  CHUNK_BITS = LANES * W;
  localparam int  REPORT_W   = 64;

  logic                                                     clk;
  logic                                                     arst_n;
  logic [mmacc_feed_pkg::MCMD_W-1:0]                        mcmd;
  logic                                                     mcmd_vld;
  logic                                                     mcmd_rdy;
  logic [LANES-1:0][1:0]                                    gram_en;
  logic [LANES-1:0][1:0][mmacc_feed_pkg::GRAM_ADD_W-1:0]    gram_add;
  logic [LANES-1:0][1:0][W-1:0]                             gram_data;
  logic [LANES-1:0][1:0]                                    gram_avail;
  logic [CHUNK_BITS-1:0]                                    out_data;
  logic [CHUNK_BITS-1:0]                                    out_diff;
  logic [mmacc_feed_pkg::CHUNK_W-1:0]                       out_chunk;
  logic                                                     out_avail;
  logic [LANES-1:0][mmacc_feed_pkg::GRAM_ADD_W-1:0]         port0_add;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS)) tb_clk_gen_i (.clk_o(clk));

  mmacc_feed_core mmacc_feed_core_i (
    .clk             (clk),
    .arst_n_i        (arst_n),
    .in_mcmd_i       (mcmd),
    .in_mcmd_vld_i   (mcmd_vld),
    .in_mcmd_rdy_o   (mcmd_rdy),
    .gram_rd_en_o    (gram_en),
    .gram_rd_add_o   (gram_add),
    .gram_rd_data_i  (gram_data),
    .gram_rd_avail_i (gram_avail),
    .out_data_o      (out_data),
    .out_diff_o      (out_diff),
    .out_chunk_o     (out_chunk),
    .out_avail_o     (out_avail)
  );

  tb_gram_model #(
    .SLOT_MUL (SLOT_MUL),
    .COEF_MUL (COEF_MUL),
    .FILL_OFS (FILL_OFS)
  ) tb_gram_model_i (
    .clk        (clk),
    .arst_n_i   (arst_n),
    .rd_en_i    (gram_en),
    .rd_add_i   (gram_add),
    .rd_data_o  (gram_data),
    .rd_avail_o (gram_avail)
  );

  for (genvar b = 0; b < LANES; b++) begin : gen_port0
    assign port0_add[b] = gram_add[b][0];
  end

  // ============================================================
  // Reference model
  // ============================================================
  function automatic int coef_value(input int slot, input int coef);
    return (slot * SLOT_MUL + coef * COEF_MUL + FILL_OFS) % Q;
  endfunction

  // (X^k * a)[i] - a[i] mod q, X^N = -1
  function automatic int cmux_diff(input int slot, input int rot, input int coef);
    int src;
    int rot_val;
    src     = (coef - rot + 2 * N) % (2 * N);
    rot_val = coef_value(slot, src % N);
    if (src >= N && rot_val != 0) rot_val = Q - rot_val;
    return (rot_val - coef_value(slot, coef) + Q) % Q;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic report_mismatch(input string test, input logic [REPORT_W-1:0] exp_v,
                                 input logic [REPORT_W-1:0] act_v);
    fail_run($sformatf("ERR %s expected 0x%0h actual 0x%0h", test, exp_v, act_v));
  endtask

  // ============================================================
  // Scoreboard
  // ============================================================
  int  cyc       = 0;
  int  rdy_hold  = 0;
  int  n_done    = 0;
  int  pending   = 0;
  logic seen_cmd = 1'b0;
  int  cmd_slot_q[$];
  int  cmd_rot_q[$];
  int  cmd_cyc_q[$];

  // Values expected at the next rising edge
  logic                                  exp_rdy   = 1'b1;
  logic                                  exp_step  = 1'b0;
  logic                                  exp_avail = 1'b0;
  logic [mmacc_feed_pkg::GRAM_ADD_W-1:0] exp_add   = '0;
  logic [mmacc_feed_pkg::CHUNK_W-1:0]    exp_chunk = '0;
  logic [CHUNK_BITS-1:0]                 exp_data  = '0;
  logic [CHUNK_BITS-1:0]                 exp_diff  = '0;

  always @(posedge clk) begin
    int age;
    int hold_v;
    int coef;
    logic step_v;
    logic avail_v;
    logic [mmacc_feed_pkg::GRAM_ADD_W-1:0] add_v;
    logic [mmacc_feed_pkg::CHUNK_W-1:0]    chunk_v;
    logic [CHUNK_BITS-1:0]                 data_v;
    logic [CHUNK_BITS-1:0]                 diff_v;
    step_v  = 1'b0;
    avail_v = 1'b0;
    add_v   = '0;
    chunk_v = '0;
    data_v  = '0;
    diff_v  = '0;
    hold_v  = rdy_hold;
    if (arst_n && mcmd_vld && mcmd_rdy) begin
      cmd_slot_q.push_back(int'(mcmd[mmacc_feed_pkg::MCMD_W-1 -: mmacc_feed_pkg::SLOT_W]));
      cmd_rot_q.push_back(int'(mcmd[mmacc_feed_pkg::ROT_W-1:0]));
      cmd_cyc_q.push_back(cyc);
      seen_cmd <= 1'b1;
      // Busy until the cycle that issues the last chunk
      hold_v = mmacc_feed_pkg::CHUNK_NB - 1;
    end else if (hold_v > 0) begin
      hold_v = hold_v - 1;
    end
    for (int idx = 0; idx < cmd_cyc_q.size(); idx++) begin
      age = cyc + 1 - cmd_cyc_q[idx];
      if (age >= 1 && age <= mmacc_feed_pkg::CHUNK_NB) begin
        step_v = 1'b1;
        add_v  = mmacc_feed_pkg::GRAM_ADD_W'(cmd_slot_q[idx] * mmacc_feed_pkg::CHUNK_NB
                                             + age - 1);
      end
      if (age >= OUT_DELAY && age < OUT_DELAY + mmacc_feed_pkg::CHUNK_NB) begin
        avail_v = 1'b1;
        chunk_v = mmacc_feed_pkg::CHUNK_W'(age - OUT_DELAY);
        for (int m = 0; m < LANES; m++) begin
          coef = (age - OUT_DELAY) * LANES + m;
          data_v[m*W +: W] = W'(coef_value(cmd_slot_q[idx], coef));
          diff_v[m*W +: W] = W'(cmux_diff(cmd_slot_q[idx], cmd_rot_q[idx], coef));
        end
      end
    end
    // Last chunk of the oldest command is due next edge
    if (cmd_cyc_q.size() > 0
        && cyc + 1 - cmd_cyc_q[0] == OUT_DELAY + mmacc_feed_pkg::CHUNK_NB - 1) begin
      void'(cmd_slot_q.pop_front());
      void'(cmd_rot_q.pop_front());
      void'(cmd_cyc_q.pop_front());
    end
    cyc       <= cyc + 1;
    rdy_hold  <= hold_v;
    pending   <= cmd_cyc_q.size();
    exp_rdy   <= (hold_v == 0);
    exp_step  <= step_v;
    exp_add   <= add_v;
    exp_avail <= avail_v;
    exp_chunk <= chunk_v;
    exp_data  <= data_v;
    exp_diff  <= diff_v;
  end

  // Polynomials that left the output with their last chunk
  always @(posedge clk) begin
    if (arst_n && out_avail
        && out_chunk == mmacc_feed_pkg::CHUNK_W'(mmacc_feed_pkg::CHUNK_NB - 1)) begin
      n_done <= n_done + 1;
    end
  end

  // ============================================================
  // Checks
  // ============================================================
  a_idle_after_reset : assert property (@(posedge clk) disable iff (!arst_n)
    !seen_cmd |-> (mcmd_rdy && !out_avail && gram_en == '0)
  ) else fail_run("Feed core not idle after reset before the first command");

  a_ready : assert property (@(posedge clk) disable iff (!arst_n)
    mcmd_rdy == exp_rdy
  ) else report_mismatch("ready", REPORT_W'($sampled(exp_rdy)), REPORT_W'($sampled(mcmd_rdy)));

  a_read_en : assert property (@(posedge clk) disable iff (!arst_n)
    gram_en == {(2 * LANES){exp_step}}
  ) else report_mismatch("read_enable", REPORT_W'({(2 * LANES){$sampled(exp_step)}}),
                         REPORT_W'($sampled(gram_en)));

  a_port0_add : assert property (@(posedge clk) disable iff (!arst_n)
    exp_step |-> port0_add == {LANES{exp_add}}
  ) else report_mismatch("port0_address", REPORT_W'({LANES{$sampled(exp_add)}}),
                         REPORT_W'($sampled(port0_add)));

  a_out_avail : assert property (@(posedge clk) disable iff (!arst_n)
    out_avail == exp_avail
  ) else report_mismatch("out_avail", REPORT_W'($sampled(exp_avail)),
                         REPORT_W'($sampled(out_avail)));

  a_out_chunk : assert property (@(posedge clk) disable iff (!arst_n)
    exp_avail |-> out_chunk == exp_chunk
  ) else report_mismatch("out_chunk", REPORT_W'($sampled(exp_chunk)),
                         REPORT_W'($sampled(out_chunk)));

  a_out_data : assert property (@(posedge clk) disable iff (!arst_n)
    exp_avail |-> out_data == exp_data
  ) else report_mismatch("out_data", REPORT_W'($sampled(exp_data)),
                         REPORT_W'($sampled(out_data)));

  a_out_diff : assert property (@(posedge clk) disable iff (!arst_n)
    exp_avail |-> out_diff == exp_diff
  ) else report_mismatch("out_diff", REPORT_W'($sampled(exp_diff)),
                         REPORT_W'($sampled(out_diff)));

  // ============================================================
  // Stimulus
  // ============================================================
  // Valid stays up until the edge that accepts the command
  task automatic send_cmd(input int slot, input int rot);
    @(negedge clk);
    mcmd = '0;
    mcmd[mmacc_feed_pkg::ROT_W-1:0] = mmacc_feed_pkg::ROT_W'(rot);
    mcmd[mmacc_feed_pkg::MCMD_W-1 -: mmacc_feed_pkg::SLOT_W] = mmacc_feed_pkg::SLOT_W'(slot);
    mcmd_vld = 1'b1;
    while (!mcmd_rdy) @(negedge clk);
  endtask

  task automatic idle_gap(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      mcmd_vld = 1'b0;
    end
  endtask

  initial begin
    int slot;
    int rot;
    arst_n   = 1'b0;
    mcmd     = '0;
    mcmd_vld = 1'b0;
    void'($urandom(SEED));
    repeat (RST_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    for (int n = 0; n < CMD_NB; n++) begin
      slot = $urandom % mmacc_feed_pkg::SLOT_NB;
      // First commands pin the rotation corners
      case (n)
        0:       rot = 0;
        1:       rot = N;
        2:       rot = 2 * N - 1;
        default: rot = $urandom % (2 * N);
      endcase
      if ($urandom % 3 == 0) idle_gap(1 + $urandom % 4);
      send_cmd(slot, rot);
    end
    idle_gap(1);
    while (pending != 0) @(negedge clk);
    repeat (mmacc_feed_pkg::CHUNK_NB + 2) @(negedge clk);
    if (n_done != CMD_NB) begin
      report_mismatch("done_count", REPORT_W'(CMD_NB), REPORT_W'(n_done));
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

  // Watchdog
  initial begin
    #((RST_CYCLES + CMD_CYCLES * CMD_NB) * CLK_PERIOD_NS);
    fail_run("Watchdog expired, the run did not finish in time");
  end

endmodule
